// File: source/pipeline_params.svh
`ifndef PIPELINE_PARAMS_SVH
`define PIPELINE_PARAMS_SVH

// Datapath and register file sizes
`define PL_DATA_W      32
`define PL_REG_ID_W    3
`define PL_NUM_GPR     8
`define PL_IMM_W       16
`define PL_INSTR_W     32
`define PL_OPC_W       3

// Instruction field positions
`define PL_OPC_LSB     29
`define PL_IMM_SEL_BIT 28
`define PL_DR_LSB      25
`define PL_SR1_LSB     22
`define PL_SR2_LSB     19

// Shift amount comes from operand B low bits
`define PL_SHAMT_W     5

`endif

// File: source/pipeline_pkg.sv
`include "pipeline_params.svh"

package pipeline_pkg;

   // ALU operations, encoded in instruction bits 31..29
   typedef enum logic [`PL_OPC_W-1:0] {
      op_add = 3'd0,
      op_sub = 3'd1,
      op_and = 3'd2,
      op_or  = 3'd3,
      op_xor = 3'd4,
      op_shl = 3'd5,
      op_shr = 3'd6,
      op_mov = 3'd7
   } opcode_e;

   typedef logic [`PL_DATA_W-1:0] data_t;

   typedef logic [`PL_REG_ID_W-1:0] reg_id_t;

   // Zero-extended to data width in the operand stage
   typedef logic [`PL_IMM_W-1:0] imm_t;

   typedef logic [`PL_INSTR_W-1:0] instr_t;

endpackage

// File: source/decode_stage.sv
`timescale 1ns/1ps
`include "pipeline_params.svh"

module decode_stage import pipeline_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    instr_valid,
   input  instr_t  instr,
   input  logic    stall,
   output logic    de_valid,
   output opcode_e de_op,
   output logic    de_imm_sel,
   output reg_id_t de_dr,
   output reg_id_t de_sr1,
   output reg_id_t de_sr2,
   output imm_t    de_imm,
   output logic    de_need_sr1,
   output logic    de_need_sr2
);

   opcode_e opc;
   logic    imm_sel;

   // Field extraction
   assign opc     = opcode_e'(instr[`PL_OPC_LSB +: `PL_OPC_W]);
   assign imm_sel = instr[`PL_IMM_SEL_BIT];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         de_valid <= 1'b0;
      end else if (!stall) begin
         de_valid <= instr_valid;
      end
   end

   // Decode latch payload that holds on stall
   always_ff @(posedge clk) begin
      if (!stall) begin
         de_op       <= opc;
         de_imm_sel  <= imm_sel;
         de_dr       <= instr[`PL_DR_LSB +: `PL_REG_ID_W];
         de_sr1      <= instr[`PL_SR1_LSB +: `PL_REG_ID_W];
         de_sr2      <= instr[`PL_SR2_LSB +: `PL_REG_ID_W];
         de_imm      <= instr[`PL_IMM_W-1:0];
         // mov takes only operand B
         de_need_sr1 <= (opc != op_mov);
         de_need_sr2 <= !imm_sel;
      end
   end

   // Held instruction must not change while the operand stage waits on it
   a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      stall |=> $stable({de_valid, de_op, de_imm_sel, de_dr, de_sr1, de_sr2,
                         de_imm, de_need_sr1, de_need_sr2}));

endmodule

// File: source/dependency_check.sv
`timescale 1ns/1ps

module dependency_check import pipeline_pkg::*; (
   input  logic    de_valid,
   input  reg_id_t de_sr1,
   input  reg_id_t de_sr2,
   input  logic    de_need_sr1,
   input  logic    de_need_sr2,
   input  logic    ex_valid,
   input  reg_id_t ex_dr,
   input  logic    wb_valid,
   input  reg_id_t wb_dr,
   output logic    stall
);

   logic sr1_busy;
   logic sr2_busy;

   // A source is busy while a write to it sits in the execute or writeback latch
   assign sr1_busy = (ex_valid && (ex_dr == de_sr1)) || (wb_valid && (wb_dr == de_sr1));
   assign sr2_busy = (ex_valid && (ex_dr == de_sr2)) || (wb_valid && (wb_dr == de_sr2));

   // No bypass paths, so any hit waits for the register file write
   assign stall = de_valid && ((de_need_sr1 && sr1_busy) || (de_need_sr2 && sr2_busy));

   always_comb begin
      a_stall_needs_valid: assert (!stall || de_valid)
         else $error("stall raised with empty decode latch");
   end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps
`include "pipeline_params.svh"

module register_file import pipeline_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  reg_id_t rd_id1,
   input  reg_id_t rd_id2,
   input  logic    wr_en,
   input  reg_id_t wr_id,
   input  data_t   wr_data,
   output data_t   rd_data1,
   output data_t   rd_data2
);

   data_t gpr [`PL_NUM_GPR];

   // Write lands at the edge, reads see it from the next cycle on
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `PL_NUM_GPR; i++) begin
            gpr[i] <= '0;
         end
      end else if (wr_en) begin
         gpr[wr_id] <= wr_data;
      end
   end

   assign rd_data1 = gpr[rd_id1];
   assign rd_data2 = gpr[rd_id2];

   a_wr_id_known: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> !$isunknown(wr_id));

endmodule

// File: source/operand_stage.sv
`timescale 1ns/1ps
`include "pipeline_params.svh"

module operand_stage import pipeline_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    stall,
   input  logic    de_valid,
   input  opcode_e de_op,
   input  logic    de_imm_sel,
   input  reg_id_t de_dr,
   input  reg_id_t de_sr1,
   input  reg_id_t de_sr2,
   input  imm_t    de_imm,
   input  data_t   rd_data1,
   input  data_t   rd_data2,
   output reg_id_t rd_id1,
   output reg_id_t rd_id2,
   output logic    ex_valid,
   output opcode_e ex_op,
   output reg_id_t ex_dr,
   output data_t   ex_a,
   output data_t   ex_b
);

   data_t imm_ext;
   data_t opnd_b;

   // Read indices straight from the decode latch
   assign rd_id1 = de_sr1;
   assign rd_id2 = de_sr2;

   assign imm_ext = {{(`PL_DATA_W - `PL_IMM_W){1'b0}}, de_imm};
   assign opnd_b  = de_imm_sel ? imm_ext : rd_data2;

   // Bubble while the decode latch waits on a busy source
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= de_valid && !stall;
      end
   end

   always_ff @(posedge clk) begin
      ex_op <= de_op;
      ex_dr <= de_dr;
      ex_a  <= rd_data1;
      ex_b  <= opnd_b;
   end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps
`include "pipeline_params.svh"

module execute_stage import pipeline_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    ex_valid,
   input  opcode_e ex_op,
   input  reg_id_t ex_dr,
   input  data_t   ex_a,
   input  data_t   ex_b,
   output logic    wb_valid,
   output reg_id_t wb_dr,
   output data_t   wb_data
);

   logic [`PL_SHAMT_W-1:0] shamt;
   data_t                  alu_result;

   assign shamt = ex_b[`PL_SHAMT_W-1:0];

   // ALU
   always_comb begin
      alu_result = ex_b;
      case (ex_op)
         op_add: alu_result = ex_a + ex_b;
         op_sub: alu_result = ex_a - ex_b;
         op_and: alu_result = ex_a & ex_b;
         op_or:  alu_result = ex_a | ex_b;
         op_xor: alu_result = ex_a ^ ex_b;
         op_shl: alu_result = ex_a << shamt;
         op_shr: alu_result = ex_a >> shamt;
         op_mov: alu_result = ex_b;
         default: alu_result = ex_b;
      endcase
   end

   // Writeback latch, also the register file write port
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= ex_valid;
      end
   end

   always_ff @(posedge clk) begin
      wb_dr   <= ex_dr;
      wb_data <= alu_result;
   end

   // No stray write right out of reset
   a_wb_quiet_after_reset: assert property (@(posedge clk)
      !rst_n |=> !wb_valid);

endmodule

// File: source/pipeline_top.sv
`timescale 1ns/1ps

module pipeline_top import pipeline_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    instr_valid,
   input  instr_t  instr,
   output logic    instr_stall,
   output logic    wb_valid,
   output reg_id_t wb_dr,
   output data_t   wb_data
);

   // Decode latch
   logic    de_valid;
   opcode_e de_op;
   logic    de_imm_sel;
   reg_id_t de_dr;
   reg_id_t de_sr1;
   reg_id_t de_sr2;
   imm_t    de_imm;
   logic    de_need_sr1;
   logic    de_need_sr2;

   // Register reads
   reg_id_t rd_id1;
   reg_id_t rd_id2;
   data_t   rd_data1;
   data_t   rd_data2;

   // Execute latch
   logic    ex_valid;
   opcode_e ex_op;
   reg_id_t ex_dr;
   data_t   ex_a;
   data_t   ex_b;

   decode_stage u_decode_stage (
      .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
      .stall(instr_stall), .de_valid(de_valid), .de_op(de_op), .de_imm_sel(de_imm_sel),
      .de_dr(de_dr), .de_sr1(de_sr1), .de_sr2(de_sr2), .de_imm(de_imm),
      .de_need_sr1(de_need_sr1), .de_need_sr2(de_need_sr2)
   );

   dependency_check u_dependency_check (
      .de_valid(de_valid), .de_sr1(de_sr1), .de_sr2(de_sr2),
      .de_need_sr1(de_need_sr1), .de_need_sr2(de_need_sr2),
      .ex_valid(ex_valid), .ex_dr(ex_dr), .wb_valid(wb_valid), .wb_dr(wb_dr),
      .stall(instr_stall)
   );

   register_file u_register_file (
      .clk(clk), .rst_n(rst_n), .rd_id1(rd_id1), .rd_id2(rd_id2),
      .wr_en(wb_valid), .wr_id(wb_dr), .wr_data(wb_data),
      .rd_data1(rd_data1), .rd_data2(rd_data2)
   );

   operand_stage u_operand_stage (
      .clk(clk), .rst_n(rst_n), .stall(instr_stall), .de_valid(de_valid),
      .de_op(de_op), .de_imm_sel(de_imm_sel), .de_dr(de_dr), .de_sr1(de_sr1),
      .de_sr2(de_sr2), .de_imm(de_imm), .rd_data1(rd_data1), .rd_data2(rd_data2),
      .rd_id1(rd_id1), .rd_id2(rd_id2), .ex_valid(ex_valid), .ex_op(ex_op),
      .ex_dr(ex_dr), .ex_a(ex_a), .ex_b(ex_b)
   );

   execute_stage u_execute_stage (
      .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_op(ex_op), .ex_dr(ex_dr),
      .ex_a(ex_a), .ex_b(ex_b), .wb_valid(wb_valid), .wb_dr(wb_dr), .wb_data(wb_data)
   );

endmodule

// File: testbench/tb_pipeline.sv
`timescale 1ns/1ps
`include "pipeline_params.svh"

module tb_pipeline import pipeline_pkg::*; ();

   localparam int          CLK_HALF     = 10;
   localparam int          RESET_CYCLES = 8;
   localparam int          DRIVE_DELAY  = 2;
   localparam int          STALL_LIMIT  = 8;
   localparam int          DRAIN_LIMIT  = 40;
   localparam int          MAX_LATENCY  = 3;
   localparam int          RANDOM_COUNT = 200;
   localparam logic [31:0] SEED         = 32'h22bd_3517;

   // One expected register write
   typedef struct {
      reg_id_t dr;
      data_t   data;
      int      acc_edge;
      bit      tight;
   } wb_exp_t;

   logic    clk;
   logic    rst_n;
   logic    instr_valid;
   instr_t  instr;
   logic    instr_stall;
   logic    wb_valid;
   reg_id_t wb_dr;
   data_t   wb_data;

   data_t   model_gpr [`PL_NUM_GPR];
   wb_exp_t exp_q [$];
   int      cyc = 0;
   int      wb_count = 0;
   bit      tight_mode = 1'b0;
   int      data_errors = 0;
   int      reg_errors = 0;
   int      proto_errors = 0;
   int      timeout_errors = 0;
   event    abort_run;

   pipeline_top dut0 (
      .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
      .instr_stall(instr_stall), .wb_valid(wb_valid), .wb_dr(wb_dr), .wb_data(wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Edge counter for latency checks
   always @(posedge clk) cyc <= cyc + 1;

   function automatic data_t alu_ref(opcode_e op, data_t a, data_t b);
      data_t r;
      case (op)
         op_add:  r = a + b;
         op_sub:  r = a - b;
         op_and:  r = a & b;
         op_or:   r = a | b;
         op_xor:  r = a ^ b;
         op_shl:  r = a << b[`PL_SHAMT_W-1:0];
         op_shr:  r = a >> b[`PL_SHAMT_W-1:0];
         default: r = b;
      endcase
      return r;
   endfunction

   function automatic instr_t make_instr(opcode_e op, logic imm_sel, reg_id_t dr,
                                         reg_id_t sr1, reg_id_t sr2, imm_t imm);
      instr_t w;
      w = '0;
      w[`PL_OPC_LSB +: `PL_OPC_W]     = op;
      w[`PL_IMM_SEL_BIT]              = imm_sel;
      w[`PL_DR_LSB +: `PL_REG_ID_W]   = dr;
      w[`PL_SR1_LSB +: `PL_REG_ID_W]  = sr1;
      w[`PL_SR2_LSB +: `PL_REG_ID_W]  = sr2;
      w[`PL_IMM_W-1:0]                = imm;
      return w;
   endfunction

   // Model update at the acceptance edge, program order
   task automatic model_accept(instr_t w);
      data_t   a;
      data_t   b;
      wb_exp_t e;
      a = model_gpr[w[`PL_SR1_LSB +: `PL_REG_ID_W]];
      if (w[`PL_IMM_SEL_BIT])
         b = {{(`PL_DATA_W - `PL_IMM_W){1'b0}}, w[`PL_IMM_W-1:0]};
      else
         b = model_gpr[w[`PL_SR2_LSB +: `PL_REG_ID_W]];
      e.dr       = w[`PL_DR_LSB +: `PL_REG_ID_W];
      e.data     = alu_ref(opcode_e'(w[`PL_OPC_LSB +: `PL_OPC_W]), a, b);
      e.acc_edge = cyc + 1;
      e.tight    = tight_mode;
      model_gpr[e.dr] = e.data;
      exp_q.push_back(e);
   endtask

   task automatic check_data(data_t got, data_t exp);
      if (got !== exp) begin
         data_errors++;
         $display("[ERROR] %0t wb_data got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic check_reg(reg_id_t got, reg_id_t exp);
      if (got !== exp) begin
         reg_errors++;
         $display("[ERROR] %0t wb_dr got %0d expected %0d", $time, got, exp);
      end
   endtask

   task automatic check_level(string name, logic got, logic exp);
      if (got !== exp) begin
         proto_errors++;
         $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   always @(negedge clk) begin : compare_wb
      wb_exp_t e;
      if (rst_n === 1'b1 && wb_valid === 1'b1) begin
         wb_count++;
         if (exp_q.size() == 0) begin
            proto_errors++;
            $display("Writeback to r%0d at %0t with no instruction outstanding", wb_dr, $time);
         end else begin
            e = exp_q.pop_front();
            check_reg(wb_dr, e.dr);
            check_data(wb_data, e.data);
            // Write edge counted from the acceptance edge
            if (e.tight && (cyc + 1 - e.acc_edge > MAX_LATENCY)) begin
               proto_errors++;
               $display("Writeback to r%0d came %0d edges after acceptance",
                        wb_dr, cyc + 1 - e.acc_edge);
            end
         end
      end
   end

   task automatic finish_run();
      int total;
      total = data_errors + reg_errors + proto_errors + timeout_errors;
      $display("Errors: data=%0d reg=%0d protocol=%0d timeout=%0d",
               data_errors, reg_errors, proto_errors, timeout_errors);
      if (total == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   endtask

   // Ends the run when a wait runs out of time
   initial begin : abort_on_timeout
      @(abort_run);
      finish_run();
   end

   // Stall sampled at the falling edge before the accepting rising edge
   task automatic issue(instr_t w);
      int waited;
      waited = 0;
      instr_valid = 1'b1;
      instr = w;
      @(negedge clk);
      while (instr_stall !== 1'b0) begin
         waited++;
         if (waited > STALL_LIMIT) begin
            timeout_errors++;
            $display("Instruction %h never accepted after %0d stalled cycles", w, waited);
            -> abort_run;
         end
         @(negedge clk);
      end
      if (waited > 2 || (tight_mode && waited != 0)) begin
         proto_errors++;
         $display("Instruction %h held off for %0d cycles", w, waited);
      end
      model_accept(w);
      @(posedge clk);
      #DRIVE_DELAY;
      instr_valid = 1'b0;
   endtask

   task automatic expect_stall();
      bit seen;
      seen = 1'b0;
      for (int n = 0; n < 3 && !seen; n++) begin
         @(negedge clk);
         seen = (instr_stall === 1'b1);
      end
      if (!seen) begin
         proto_errors++;
         $display("No stall seen after a dependent instruction at %0t", $time);
      end
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         if (n >= DRAIN_LIMIT) begin
            timeout_errors++;
            $display("%0d writebacks still missing after %0d cycles", exp_q.size(), n);
            -> abort_run;
         end
         @(posedge clk);
         n++;
      end
      #DRIVE_DELAY;
   endtask

   task automatic check_idle(int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_level("wb_valid", wb_valid, 1'b0);
         check_level("instr_stall", instr_stall, 1'b0);
      end
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   initial begin
      int unsigned seed_ret;
      instr_t      w;
      imm_t        imm;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      for (int i = 0; i < `PL_NUM_GPR; i++) model_gpr[i] = '0;
      seed_ret = $urandom(SEED);
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;

      check_idle(6);

      // r1 gets beef1357 from immediates and r2 gets 0c2d
      issue(make_instr(op_mov, 1'b1, 3'd1, 3'd0, 3'd0, 16'hbeef));
      issue(make_instr(op_shl, 1'b1, 3'd1, 3'd1, 3'd0, 16'd16));
      issue(make_instr(op_or,  1'b1, 3'd1, 3'd1, 3'd0, 16'h1357));
      issue(make_instr(op_mov, 1'b1, 3'd2, 3'd0, 3'd0, 16'h0c2d));
      for (int k = 0; k < 8; k++)
         issue(make_instr(opcode_e'(k[2:0]), 1'b0, 3'd3, 3'd1, 3'd2, 16'h0));

      // Upper immediate bits set to catch sign extension
      for (int k = 0; k < 8; k++) begin
         imm = 16'hffe0 | imm_t'(k + 3);
         issue(make_instr(opcode_e'(k[2:0]), 1'b1, 3'd4, 3'd1, 3'd0, imm));
      end
      wait_drain();

      issue(make_instr(op_add, 1'b0, 3'd5, 3'd1, 3'd2, 16'h0));
      issue(make_instr(op_sub, 1'b0, 3'd6, 3'd5, 3'd1, 16'h0));
      expect_stall();
      issue(make_instr(op_xor, 1'b0, 3'd7, 3'd2, 3'd6, 16'h0));
      expect_stall();
      wait_drain();

      // No source below is in flight when it reaches decode
      tight_mode = 1'b1;
      issue(make_instr(op_mov, 1'b1, 3'd4, 3'd0, 3'd0, 16'h7a31));
      issue(make_instr(op_mov, 1'b1, 3'd5, 3'd0, 3'd0, 16'h0456));
      issue(make_instr(op_add, 1'b0, 3'd6, 3'd1, 3'd2, 16'h0));
      issue(make_instr(op_xor, 1'b0, 3'd7, 3'd3, 3'd1, 16'h0));
      issue(make_instr(op_sub, 1'b0, 3'd0, 3'd4, 3'd5, 16'h0));
      wait_drain();
      tight_mode = 1'b0;

      wb_count = 0;
      for (int k = 0; k < RANDOM_COUNT; k++) begin
         w = $urandom();
         issue(w);
      end
      wait_drain();
      // Late extra writebacks would show up here
      check_idle(4);
      if (wb_count != RANDOM_COUNT) begin
         proto_errors++;
         $display("Random stream gave %0d writebacks instead of %0d", wb_count, RANDOM_COUNT);
      end
      finish_run();
   end

endmodule

// File: flist.f
+incdir+source
source/pipeline_pkg.sv
source/decode_stage.sv
source/dependency_check.sv
source/register_file.sv
source/operand_stage.sv
source/execute_stage.sv
source/pipeline_top.sv
testbench/tb_pipeline.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_pipeline
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation PASSED" $(LOG) || { echo "Failure reported, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
